// File: source/isaPkg.sv
package isaPkg;

   localparam int wordWidth    = 16;
   localparam int regAddrWidth = 3;

   // instruction field layout
   localparam int fieldGrpHi  = 15;
   localparam int fieldGrpLo  = 14;
   localparam int fieldRsHi   = 13; // also Ra, sub-opcode
   localparam int fieldRsLo   = 11;
   localparam int fieldRdHi   = 10; // also Rb, branch cond
   localparam int fieldRdLo   = 8;
   localparam int fieldOp3Hi  = 7;
   localparam int fieldOp3Lo  = 4;
   localparam int fieldD4Hi   = 3;
   localparam int fieldD4Lo   = 0;
   localparam int fieldD8Hi   = 7;
   localparam int fieldD8Lo   = 0;

   typedef enum logic [1:0] {
      grpLoad  = 2'b00,
      grpStore = 2'b01,
      grpImm   = 2'b10,
      grpArith = 2'b11
   } instrGroupT;

   typedef enum logic [2:0] {
      immLi         = 3'b000,
      immAddi       = 3'b001,
      immBranch     = 3'b100,
      immCondBranch = 3'b111
   } immOpT;

   typedef enum logic [3:0] {
      opAdd = 4'b0000,
      opSub = 4'b0001,
      opAnd = 4'b0010,
      opOr  = 4'b0011,
      opXor = 4'b0100,
      opCmp = 4'b0101,
      opMov = 4'b0110,
      opSll = 4'b1000,
      opSlr = 4'b1001, // rotate left
      opSrl = 4'b1010,
      opSra = 4'b1011,
      opIn  = 4'b1100,
      opOut = 4'b1101,
      opHlt = 4'b1111
   } arithOpT;

   typedef enum logic [2:0] {
      condEq = 3'b000,
      condLt = 3'b001,
      condLe = 3'b010,
      condNe = 3'b011
   } condT;

   typedef enum logic [3:0] {
      aluAdd   = 4'b0000,
      aluSub   = 4'b0001,
      aluAnd   = 4'b0010,
      aluOr    = 4'b0011,
      aluXor   = 4'b0100,
      aluSll   = 4'b1000,
      aluSlr   = 4'b1001,
      aluSrl   = 4'b1010,
      aluSra   = 4'b1011,
      aluPassB = 4'b1100,
      aluNone  = 4'b1111
   } aluOpT;

endpackage

// File: source/corePkg.sv
package corePkg;

   import isaPkg::*;

   typedef struct packed {
      logic sign;
      logic zero;
      logic carry;
      logic overflow;
   } flagsT;

   typedef struct packed {
      aluOpT                   aluOp;
      logic                    aSelPc;   // A = PC+1
      logic                    bSelImm;  // B = sign-extended d
      logic                    immShort; // 4-bit d instead of 8-bit
      logic                    regWrite;
      logic [regAddrWidth-1:0] writeAddr;
      logic                    wbSelMem;
      logic                    wbSelIn;
      logic                    memWrite;
      logic                    flagsWrite;
      logic                    ioOut;
      logic                    jump;
      logic                    condJump;
      condT                    cond;
      logic                    halt;
   } ctrlT;

   typedef enum logic [1:0] {
      phFetch = 2'b00,
      phExec  = 2'b01,
      phHalt  = 2'b10
   } phaseT;

endpackage

// File: source/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit
   import isaPkg::*;
   import corePkg::*;
(
   input  logic [wordWidth-1:0] instrReg,
   output ctrlT                 ctrl
);

   instrGroupT group;
   arithOpT    op3;
   immOpT      subOp;

   assign group = instrGroupT'(instrReg[fieldGrpHi:fieldGrpLo]);
   assign op3   = arithOpT'(instrReg[fieldOp3Hi:fieldOp3Lo]);
   assign subOp = immOpT'(instrReg[fieldRsHi:fieldRsLo]);

   always_comb begin
      ctrl           = '0;
      ctrl.aluOp     = aluNone;
      ctrl.cond      = condT'(instrReg[fieldRdHi:fieldRdLo]);
      ctrl.writeAddr = instrReg[fieldRdHi:fieldRdLo];

      case (group)
         grpArith: begin
            ctrl.immShort = 1'b1; // shift amount lives in d
            case (op3)
               opAdd, opSub, opAnd, opOr, opXor: begin
                  ctrl.aluOp      = aluOpT'(op3);
                  ctrl.regWrite   = 1'b1;
                  ctrl.flagsWrite = 1'b1;
               end
               opCmp: begin
                  ctrl.aluOp      = aluSub;
                  ctrl.flagsWrite = 1'b1;
               end
               opMov: begin
                  ctrl.aluOp      = aluPassB;
                  ctrl.regWrite   = 1'b1;
                  ctrl.flagsWrite = 1'b1;
               end
               opSll, opSlr, opSrl, opSra: begin
                  ctrl.aluOp      = aluOpT'(op3);
                  ctrl.bSelImm    = 1'b1;
                  ctrl.regWrite   = 1'b1;
                  ctrl.flagsWrite = 1'b1;
               end
               opIn: begin
                  ctrl.regWrite = 1'b1;
                  ctrl.wbSelIn  = 1'b1;
               end
               opOut:   ctrl.ioOut = 1'b1;
               opHlt:   ctrl.halt  = 1'b1;
               default: ;  // undefined op3, nop
            endcase
         end
         grpLoad: begin
            ctrl.aluOp     = aluAdd;
            ctrl.bSelImm   = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.wbSelMem  = 1'b1;
            ctrl.writeAddr = instrReg[fieldRsHi:fieldRsLo]; // Ra
         end
         grpStore: begin
            ctrl.aluOp    = aluAdd;
            ctrl.bSelImm  = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         default: begin
            // immediates and branches
            case (subOp)
               immLi: begin
                  ctrl.aluOp    = aluPassB;
                  ctrl.bSelImm  = 1'b1;
                  ctrl.regWrite = 1'b1;
               end
               immAddi: begin
                  ctrl.aluOp    = aluAdd;
                  ctrl.bSelImm  = 1'b1;
                  ctrl.regWrite = 1'b1;
               end
               immBranch, immCondBranch: begin
                  ctrl.aluOp    = aluAdd; // target = PC+1 + d
                  ctrl.aSelPc   = 1'b1;
                  ctrl.bSelImm  = 1'b1;
                  ctrl.jump     = (subOp == immBranch);
                  ctrl.condJump = (subOp == immCondBranch);
               end
               default: ;
            endcase
         end
      endcase
   end

endmodule

// File: source/aluShifter.sv
`timescale 1ns/1ps

module aluShifter
   import isaPkg::*;
   import corePkg::*;
(
   input  aluOpT                op,
   input  logic [wordWidth-1:0] a,
   input  logic [wordWidth-1:0] b,
   output logic [wordWidth-1:0] result,
   output flagsT                flags
);

   logic [3:0]           shAmt;
   logic [wordWidth:0]   sumExt;
   logic [wordWidth:0]   diffExt;
   logic [wordWidth:0]   shlExt;
   logic [wordWidth:0]   shrExt;
   logic [wordWidth:0]   sraExt;
   logic [wordWidth-1:0] rotated;

   assign shAmt   = b[3:0];
   assign sumExt  = {1'b0, a} + {1'b0, b};
   assign diffExt = {1'b0, a} - {1'b0, b}; // msb is the borrow
   // one spare bit catches the last bit shifted out
   assign shlExt  = {1'b0, a} << shAmt;
   assign shrExt  = {a, 1'b0} >> shAmt;
   assign sraExt  = $signed({a, 1'b0}) >>> shAmt;
   assign rotated = (a << shAmt) | (a >> (5'd16 - {1'b0, shAmt}));

   always_comb begin
      result         = '0;
      flags.carry    = 1'b0;
      flags.overflow = 1'b0;
      case (op)
         aluAdd: begin
            result         = sumExt[wordWidth-1:0];
            flags.carry    = sumExt[wordWidth];
            flags.overflow = (a[wordWidth-1] == b[wordWidth-1]) &&
                             (result[wordWidth-1] != a[wordWidth-1]);
         end
         aluSub: begin
            result         = diffExt[wordWidth-1:0];
            flags.carry    = diffExt[wordWidth];
            flags.overflow = (a[wordWidth-1] != b[wordWidth-1]) &&
                             (result[wordWidth-1] != a[wordWidth-1]);
         end
         aluAnd:   result = a & b;
         aluOr:    result = a | b;
         aluXor:   result = a ^ b;
         aluSll: begin
            result      = shlExt[wordWidth-1:0];
            flags.carry = shlExt[wordWidth];
         end
         aluSlr: begin
            result      = rotated;
            flags.carry = (shAmt != 4'd0) && rotated[0]; // bit wrapped around
         end
         aluSrl: begin
            result      = shrExt[wordWidth:1];
            flags.carry = shrExt[0];
         end
         aluSra: begin
            result      = sraExt[wordWidth:1];
            flags.carry = sraExt[0];
         end
         aluPassB: result = b;
         default:  result = '0;
      endcase
      flags.sign = result[wordWidth-1];
      flags.zero = (result == '0);
   end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile
   import isaPkg::*;
(
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [regAddrWidth-1:0] addrA,
   input  logic [regAddrWidth-1:0] addrB,
   output logic [wordWidth-1:0]    dataA,
   output logic [wordWidth-1:0]    dataB,
   input  logic                    writeEn,
   input  logic [regAddrWidth-1:0] writeAddr,
   input  logic [wordWidth-1:0]    writeData
);

   logic [wordWidth-1:0] regs [2**regAddrWidth];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regAddrWidth; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   assign dataA = regs[addrA];
   assign dataB = regs[addrB];

endmodule

// File: source/branchUnit.sv
`timescale 1ns/1ps

module branchUnit
   import isaPkg::*;
   import corePkg::*;
(
   input  logic  clk,
   input  logic  rstN,
   input  flagsT flagsIn,
   input  logic  flagsWrite,
   input  ctrlT  ctrl,
   output logic  taken
);

   flagsT flagReg;
   logic  lessThan;
   logic  condMet;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         flagReg <= '0;
      end else if (flagsWrite) begin
         flagReg <= flagsIn;
      end
   end

   // signed compare from the last CMP/SUB
   assign lessThan = flagReg.sign ^ flagReg.overflow;

   always_comb begin
      case (ctrl.cond)
         condEq:  condMet = flagReg.zero;
         condLt:  condMet = lessThan;
         condLe:  condMet = flagReg.zero | lessThan;
         condNe:  condMet = !flagReg.zero;
         default: condMet = 1'b0; // reserved codes never branch
      endcase
   end

   assign taken = ctrl.jump | (ctrl.condJump & condMet);

endmodule

// File: source/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer
   import isaPkg::*;
   import corePkg::*;
#(
   parameter logic [wordWidth-1:0] resetPc = '0
) (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [wordWidth-1:0] instr,
   input  ctrlT                 ctrl,
   input  logic                 taken,
   input  logic [wordWidth-1:0] branchTarget,
   output logic [wordWidth-1:0] instrAddr,
   output logic [wordWidth-1:0] instrReg,
   output logic                 execEn,
   output logic                 halted
);

   phaseT                phase;
   logic [wordWidth-1:0] pc;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         phase <= phFetch;
         pc    <= resetPc;
      end else begin
         case (phase)
            phFetch: phase <= phExec;
            phExec: begin
               if (ctrl.halt) begin
                  phase <= phHalt; // pc stays on the HLT
               end else begin
                  phase <= phFetch;
                  pc    <= taken ? branchTarget : pc + 1'b1;
               end
            end
            phHalt:  phase <= phHalt;
            default: phase <= phFetch;
         endcase
      end
   end

   // instruction register, loaded in fetch only
   always_ff @(posedge clk) begin
      if (phase == phFetch) begin
         instrReg <= instr;
      end
   end

   assign instrAddr = pc;
   assign execEn    = (phase == phExec);
   assign halted    = (phase == phHalt);

endmodule

// File: source/simpleCore.sv
`timescale 1ns/1ps

module simpleCore
   import isaPkg::*;
   import corePkg::*;
#(
   parameter logic [wordWidth-1:0] resetPc = '0
) (
   input  logic                 clk,
   input  logic                 rstN,
   output logic [wordWidth-1:0] instrAddr,
   input  logic [wordWidth-1:0] instr,
   output logic [wordWidth-1:0] dataAddr,
   output logic [wordWidth-1:0] dataWrite,
   input  logic [wordWidth-1:0] dataRead,
   output logic                 dataWe,
   input  logic [wordWidth-1:0] ioIn,
   output logic [wordWidth-1:0] ioOut,
   output logic                 ioOutValid,
   output logic                 halted
);

   logic [wordWidth-1:0] instrReg;
   logic [wordWidth-1:0] dataA;
   logic [wordWidth-1:0] dataB;
   logic [wordWidth-1:0] opA;
   logic [wordWidth-1:0] opB;
   logic [wordWidth-1:0] imm;
   logic [wordWidth-1:0] aluResult;
   logic [wordWidth-1:0] wbData;
   logic [wordWidth-1:0] pcPlusOne;
   ctrlT                 ctrl;
   flagsT                aluFlags;
   logic                 execEn;
   logic                 taken;

   decodeUnit decode_i (.instrReg(instrReg), .ctrl(ctrl));

   coreSequencer #(.resetPc(resetPc)) seq_i (
      .clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl), .taken(taken),
      .branchTarget(aluResult), .instrAddr(instrAddr), .instrReg(instrReg),
      .execEn(execEn), .halted(halted)
   );

   // A reads Rd/Rb, B reads Rs/Ra
   registerFile regs_i (
      .clk(clk), .rstN(rstN),
      .addrA(instrReg[fieldRdHi:fieldRdLo]), .addrB(instrReg[fieldRsHi:fieldRsLo]),
      .dataA(dataA), .dataB(dataB),
      .writeEn(execEn & ctrl.regWrite), .writeAddr(ctrl.writeAddr), .writeData(wbData)
   );

   assign pcPlusOne = instrAddr + 1'b1; // pc still holds this instruction
   assign imm = ctrl.immShort ? wordWidth'(signed'(instrReg[fieldD4Hi:fieldD4Lo]))
                              : wordWidth'(signed'(instrReg[fieldD8Hi:fieldD8Lo]));
   assign opA = ctrl.aSelPc ? pcPlusOne : dataA;
   assign opB = ctrl.bSelImm ? imm : dataB;

   aluShifter alu_i (.op(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult), .flags(aluFlags));

   branchUnit branch_i (
      .clk(clk), .rstN(rstN), .flagsIn(aluFlags),
      .flagsWrite(execEn & ctrl.flagsWrite), .ctrl(ctrl), .taken(taken)
   );

   always_comb begin
      if (ctrl.wbSelMem)     wbData = dataRead;
      else if (ctrl.wbSelIn) wbData = ioIn;
      else                   wbData = aluResult;
   end

   assign dataAddr   = aluResult;
   assign dataWrite  = dataB;
   assign dataWe     = execEn & ctrl.memWrite;
   assign ioOut      = dataB;
   assign ioOutValid = execEn & ctrl.ioOut;

endmodule

// File: testbench/simpleCore_asserts.sv
`timescale 1ns/1ps

module simpleCoreAsserts (
   input logic        clk,
   input logic        rstN,
   input logic        dataWe,
   input logic        ioOutValid,
   input logic        halted,
   input logic [15:0] instrAddr
);

   noStoreAndOut: assert property (@(posedge clk) !(dataWe && ioOutValid))
      else $error("store and output strobes high together");

   haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
      else $error("halted dropped");

   // pc frozen once halted
   pcFrozen: assert property (@(posedge clk) disable iff (!rstN)
      halted |=> $stable(instrAddr))
      else $error("instrAddr moved while halted");

   quietInReset: assert property (@(posedge clk)
      (!rstN ##1 !rstN) |-> (!dataWe && !ioOutValid))
      else $error("strobe high during reset");

endmodule

bind simpleCore simpleCoreAsserts asserts_i (
   .clk(clk), .rstN(rstN), .dataWe(dataWe), .ioOutValid(ioOutValid),
   .halted(halted), .instrAddr(instrAddr)
);

// File: testbench/simpleCoreTb.sv
`timescale 1ns/1ps

module simpleCoreTb
   import isaPkg::*;
   import corePkg::*;
;

   localparam int maxWait   = 400;
   localparam int maxSteps  = 500;
   localparam int maxEvents = 200;

   logic                 clk;
   logic                 rstN;
   logic [wordWidth-1:0] instrAddr;
   logic [wordWidth-1:0] instr;
   logic [wordWidth-1:0] dataAddr;
   logic [wordWidth-1:0] dataWrite;
   logic [wordWidth-1:0] dataRead;
   logic                 dataWe;
   logic [wordWidth-1:0] ioIn;
   logic [wordWidth-1:0] ioOut;
   logic                 ioOutValid;
   logic                 halted;

   logic [wordWidth-1:0] imem [128];
   logic [wordWidth-1:0] dmem [256];
   int                   progLen;
   logic [31:0]          lcgState;
   logic                 execPhase;
   logic [wordWidth-1:0] ioQ [$];

   // reference model state
   logic [wordWidth-1:0] mRegs [8];
   logic [wordWidth-1:0] mMem [256];
   logic [wordWidth-1:0] mPc;
   flagsT                mFlags;
   logic [wordWidth-1:0] evAddr;
   logic [wordWidth-1:0] evData;
   int                   errors;
   int                   checks;

   simpleCore #(.resetPc(16'h0000)) dut_i (
      .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
      .dataAddr(dataAddr), .dataWrite(dataWrite), .dataRead(dataRead), .dataWe(dataWe),
      .ioIn(ioIn), .ioOut(ioOut), .ioOutValid(ioOutValid), .halted(halted)
   );

   assign instr    = imem[instrAddr[6:0]];
   assign dataRead = dmem[dataAddr[7:0]];

   always @(posedge clk) begin
      if (dataWe) dmem[dataAddr[7:0]] <= dataWrite;
   end

   function automatic logic [15:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[31:16];
   endfunction

   function automatic logic [15:0] encArith(arithOpT op, int rs, int rd, int d);
      return {2'b11, 3'(rs), 3'(rd), 4'(op), 4'(d)};
   endfunction

   function automatic logic [15:0] encMem(logic [1:0] grp, int ra, int rb, int d);
      return {grp, 3'(ra), 3'(rb), 8'(d)};
   endfunction

   function automatic logic [15:0] encImm(immOpT sub, int rd, int d);
      return {2'b10, 3'(sub), 3'(rd), 8'(d)};
   endfunction

   task automatic emit(input logic [15:0] w);
      imem[progLen] = w;
      progLen++;
   endtask

   task automatic binaryCase(input arithOpT op);
      emit(encArith(opMov, 1, 3, 0));
      emit(encArith(op, 2, 3, 0)); // r3 = r1 op r2
      emit(encArith(opOut, 3, 0, 0));
   endtask

   task automatic shiftCase(input arithOpT op, input int n);
      emit(encArith(opMov, 2, 3, 0));
      emit(encArith(op, 0, 3, n));
      emit(encArith(opOut, 3, 0, 0));
   endtask

   // out r2 only when the branch is taken, else r1 then r2
   task automatic condCase(input int rd, input int rs, input condT c);
      emit(encArith(opCmp, rs, rd, 0));
      emit(encImm(immCondBranch, int'(c), 1));
      emit(encArith(opOut, 1, 0, 0));
      emit(encArith(opOut, 2, 0, 0));
   endtask

   // one instruction on the model, returns 1 store, 2 output, 3 halt
   function automatic int refStep();
      logic [15:0] w;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] d8;
      logic [16:0] t;
      logic [2:0]  rs;
      logic [2:0]  rd;
      logic [3:0]  n;
      logic        c;
      logic        v;
      logic        met;
      int          kind;
      w    = imem[mPc[6:0]];
      rs   = w[13:11];
      rd   = w[10:8];
      n    = w[3:0];
      d8   = {{8{w[7]}}, w[7:0]};
      a    = mRegs[rd];
      b    = mRegs[rs];
      kind = 0;
      c    = 1'b0;
      v    = 1'b0;
      case (w[15:14])
         2'b11: begin
            r = 16'h0;
            case (w[7:4])
               4'h0: begin
                  t = {1'b0, a} + {1'b0, b};
                  r = t[15:0];
                  c = t[16];
                  v = (a[15] == b[15]) && (r[15] != a[15]);
               end
               4'h1, 4'h5: begin
                  r = a - b;
                  c = a < b;
                  v = (a[15] != b[15]) && (r[15] != a[15]);
               end
               4'h2: r = a & b;
               4'h3: r = a | b;
               4'h4: r = a ^ b;
               4'h6: r = b;
               4'h8: begin
                  r = a << n;
                  c = (n != 0) ? a[16 - n] : 1'b0;
               end
               4'h9: begin
                  r = (n == 0) ? a : ((a << n) | (a >> (16 - n)));
                  c = (n != 0) ? a[16 - n] : 1'b0;
               end
               4'hA: begin
                  r = a >> n;
                  c = (n != 0) ? a[n - 1] : 1'b0;
               end
               4'hB: begin
                  r = 16'($signed(a) >>> n);
                  c = (n != 0) ? a[n - 1] : 1'b0;
               end
               default: ;
            endcase
            if (w[7:4] <= 4'h6 || (w[7:4] >= 4'h8 && w[7:4] <= 4'hB)) begin
               mFlags = '{sign: r[15], zero: (r == 16'h0), carry: c, overflow: v};
               if (w[7:4] != 4'h5) mRegs[rd] = r;
            end
            if (w[7:4] == 4'hC) mRegs[rd] = ioQ.pop_front();
            if (w[7:4] == 4'hD) begin
               kind   = 2;
               evData = b;
            end
            if (w[7:4] == 4'hF) return 3; // pc stays on HLT
            mPc = mPc + 16'd1;
         end
         2'b00: begin
            t = {1'b0, a + d8};
            mRegs[rs] = mMem[t[7:0]];
            mPc = mPc + 16'd1;
         end
         2'b01: begin
            evAddr = a + d8;
            evData = b;
            mMem[evAddr[7:0]] = b;
            kind = 1;
            mPc = mPc + 16'd1;
         end
         default: begin
            met = 1'b0;
            case (rd)
               3'd0: met = mFlags.zero;
               3'd1: met = mFlags.sign ^ mFlags.overflow;
               3'd2: met = mFlags.zero | (mFlags.sign ^ mFlags.overflow);
               3'd3: met = !mFlags.zero;
               default: ;
            endcase
            if (rs == 3'd0) mRegs[rd] = d8;
            if (rs == 3'd1) mRegs[rd] = a + d8;
            if (rs == 3'd4 || (rs == 3'd7 && met)) mPc = mPc + 16'd1 + d8;
            else mPc = mPc + 16'd1;
         end
      endcase
      return kind;
   endfunction

   function automatic int advanceModel();
      int k;
      for (int i = 0; i < maxSteps; i++) begin
         k = refStep();
         if (k != 0) return k;
      end
      return 0;
   endfunction

   task automatic compareValue(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      if (!rstN) execPhase <= 1'b0;
      else execPhase <= !execPhase;
   end

   // new ioIn value after every IN
   always @(posedge clk) begin
      if (rstN && execPhase && instr[15:14] == 2'b11 && instr[7:4] == 4'(opIn)) begin
         #1;
         ioIn = lcgNext();
         ioQ.push_back(ioIn);
      end
   end

   initial begin
      rstN     = 1'b0;
      lcgState = 32'h66a6_2147;
      progLen  = 0;
      errors   = 0;
      checks   = 0;
      ioIn     = lcgNext();
      ioQ.push_back(ioIn);
      for (int i = 0; i < 128; i++) imem[i] = 16'h0000;
      for (int i = 0; i < 256; i++) begin
         dmem[i] = lcgNext();
         mMem[i] = dmem[i];
      end
      for (int i = 0; i < 8; i++) mRegs[i] = 16'h0;
      mPc    = 16'h0;
      mFlags = '0;

      emit(encImm(immLi, 1, 8'h36));
      emit(encImm(immLi, 2, 8'hFD));
      emit(encArith(opOut, 1, 0, 0));
      emit(encArith(opOut, 2, 0, 0));
      binaryCase(opAdd);
      binaryCase(opSub);
      binaryCase(opAnd);
      binaryCase(opOr);
      binaryCase(opXor);
      shiftCase(opSll, 5);
      shiftCase(opSlr, 5);
      shiftCase(opSrl, 5);
      shiftCase(opSra, 5);
      emit(encImm(immLi, 4, 8'h10));
      emit(encMem(2'b00, 5, 4, 3));
      emit(encArith(opOut, 5, 0, 0));
      emit(encMem(2'b00, 5, 4, 8'hFE)); // negative displacement
      emit(encArith(opOut, 5, 0, 0));
      emit(encImm(immAddi, 4, 8'h20));
      emit(encMem(2'b01, 1, 4, 1));
      emit(encMem(2'b01, 2, 4, 8'hFC));
      emit(encMem(2'b00, 6, 4, 1));
      emit(encArith(opOut, 6, 0, 0));
      for (int c = 0; c < 4; c++) condCase(1, 2, condT'(c)); // greater
      for (int c = 0; c < 4; c++) condCase(2, 1, condT'(c)); // less
      for (int c = 0; c < 4; c++) condCase(1, 1, condT'(c)); // equal
      emit(encArith(opMov, 2, 3, 0));
      emit(encArith(opSub, 2, 3, 0)); // zero result from SUB
      emit(encImm(immCondBranch, int'(condEq), 1));
      emit(encArith(opOut, 1, 0, 0));
      emit(encArith(opOut, 2, 0, 0));
      emit(encImm(immLi, 7, 3));
      emit(encArith(opOut, 7, 0, 0)); // loop head
      emit(encImm(immAddi, 7, 8'hFF));
      emit(encArith(opCmp, 0, 7, 0));
      emit(encImm(immCondBranch, int'(condEq), 1));
      emit(encImm(immBranch, 0, 8'hFB)); // back to loop head
      emit(encArith(opIn, 0, 5, 0));
      emit(encArith(opOut, 5, 0, 0));
      emit(encArith(opIn, 0, 5, 0));
      emit(encArith(opOut, 5, 0, 0));
      emit(encArith(opHlt, 0, 0, 0));
      emit(encArith(opOut, 1, 0, 0));
      emit(encMem(2'b01, 1, 4, 0));

      repeat (16) @(posedge clk);
      #1 rstN = 1'b1;
   end

   initial begin : compareProc
      int  cycles;
      int  kind;
      int  events;
      bit  done;
      done   = 1'b0;
      events = 0;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!rstN && cycles < maxWait);
      if (!rstN) begin
         errors++;
         $display("Timeout: reset was never released");
         done = 1'b1;
      end
      while (!done) begin
         cycles = 0;
         @(negedge clk);
         while (!(dataWe || ioOutValid || halted) && cycles < maxWait) begin
            @(negedge clk);
            cycles++;
         end
         if (!(dataWe || ioOutValid || halted)) begin
            errors++;
            $display("Timeout: the DUT made no store, output or halt");
            done = 1'b1;
         end else if (events >= maxEvents) begin
            errors++;
            $display("Timeout: the DUT did not halt");
            done = 1'b1;
         end else begin
            events++;
            kind = advanceModel();
            if (halted) begin
               compareValue("halt event", 16'd3, 16'(kind));
               compareValue("halt pc", instrAddr, mPc);
               done = 1'b1;
            end else if (dataWe) begin
               compareValue("store event", 16'd1, 16'(kind));
               compareValue("store address", dataAddr, evAddr);
               compareValue("store data", dataWrite, evData);
            end else begin
               compareValue("output event", 16'd2, 16'(kind));
               compareValue("output value", ioOut, evData);
            end
         end
      end
      repeat (20) begin
         @(negedge clk);
         if (dataWe || ioOutValid) begin
            errors++;
            $display("Fail %0t: store or output after halt", $time);
         end
      end
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: project.f
source/isaPkg.sv
source/corePkg.sv
source/decodeUnit.sv
source/aluShifter.sv
source/registerFile.sv
source/branchUnit.sv
source/coreSequencer.sv
source/simpleCore.sv
testbench/simpleCore_asserts.sv
testbench/simpleCoreTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = simpleCoreTb
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
